//--- source/dcache_pkg.sv
// data cache shared definitions
`default_nettype none

package dcache_pkg;

	// ----------------------------------------
	// geometry
	// ----------------------------------------
	localparam int NUM_WAYS       = 2;
	localparam int NUM_SETS       = 4;
	localparam int WORDS_PER_LINE = 4;
	localparam int WORD_BITS      = 32;
	localparam int LINE_BITS      = 128;
	localparam int WORD_ADDR_BITS = 30;
	localparam int TAG_BITS       = 26;

	// ----------------------------------------
	// vector types
	// ----------------------------------------
	typedef logic [WORD_BITS-1:0]      word_t;      // processor data word
	typedef logic [WORD_ADDR_BITS-1:0] word_addr_t; // tag | index | offset
	typedef logic [LINE_BITS-1:0]      line_t;      // one line, one memory beat

	// memory side drops the word offset
	typedef logic [WORD_ADDR_BITS-3:0] line_addr_t;

	typedef logic [TAG_BITS-1:0]                 tag_t;
	typedef logic [$clog2(NUM_SETS)-1:0]         index_t;
	typedef logic [$clog2(WORDS_PER_LINE)-1:0]   offset_t;
	typedef logic [$clog2(NUM_WAYS)-1:0]         way_t;

	// miss handling states
	typedef enum logic [1:0] {
		compare_tag, // lookup, serve hits
		write_back,  // dirty victim out to memory
		allocate     // requested line in from memory
	} cache_state_t;

endpackage

`default_nettype wire

//--- source/dcache_store_if.sv
// controller to storage link
`timescale 1ns/100ps
`default_nettype none

interface dcache_store_if (
	input logic clk
);
	import dcache_pkg::*;

	// lookup results
	logic       hit;
	way_t       hit_way;
	logic       victim_dirty;
	line_addr_t victim_line_addr;  // victim tag plus set index
	line_t      victim_line;

	// single-cycle update commands
	logic       write_hit;
	logic       fill;
	logic       clean;

	modport ctrl (
		input  clk,
		input  hit, victim_dirty, victim_line_addr,
		output write_hit, fill, clean
	);

	modport store (
		input  clk,
		input  write_hit, fill, clean,
		output hit, hit_way, victim_dirty, victim_line_addr, victim_line
	);

endinterface

`default_nettype wire

//--- source/dcache_store.sv
// cache arrays and lookup
`timescale 1ns/100ps
`default_nettype none

module dcache_store (
	input  logic                  clk,
	input  logic                  proc_reset,
	input  logic                  proc_read,
	input  dcache_pkg::word_addr_t proc_addr,
	input  dcache_pkg::word_t     proc_wdata,
	input  dcache_pkg::line_t     mem_rdata,
	output dcache_pkg::word_t     proc_rdata,
	dcache_store_if.store         st
);
	import dcache_pkg::*;

	// ----------------------------------------
	// arrays
	// ----------------------------------------
	tag_t                tag_q   [NUM_SETS][NUM_WAYS];
	line_t               data_q  [NUM_SETS][NUM_WAYS];
	logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
	logic [NUM_WAYS-1:0] dirty_q [NUM_SETS];
	way_t                repl_q  [NUM_SETS];  // way to evict next

	index_t              idx;
	tag_t                req_tag;
	offset_t             word_sel;
	logic [NUM_WAYS-1:0] way_hit;
	way_t                victim;
	line_t               hit_line;
	logic                read_hit;

	// address split
	assign word_sel = proc_addr[1:0];
	assign idx      = proc_addr[3:2];
	assign req_tag  = proc_addr[WORD_ADDR_BITS-1:4];

	// ----------------------------------------
	// lookup
	// ----------------------------------------
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			way_hit[w] = valid_q[idx][w] && (tag_q[idx][w] == req_tag);
		end
	end

	assign st.hit     = |way_hit;
	assign st.hit_way = way_hit[1];  // only two ways
	assign read_hit   = proc_read && st.hit;

	assign victim              = repl_q[idx];
	assign st.victim_dirty     = dirty_q[idx][victim];
	assign st.victim_line_addr = {tag_q[idx][victim], idx};
	assign st.victim_line      = data_q[idx][victim];

	// word out of the hit line, zero when idle
	assign hit_line   = data_q[idx][st.hit_way];
	assign proc_rdata = read_hit ? hit_line[word_sel*WORD_BITS +: WORD_BITS] : '0;

	// ----------------------------------------
	// state bits
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				valid_q[s] <= '0;
				dirty_q[s] <= '0;
				repl_q[s]  <= '0;
			end
		end else begin
			if (st.fill) begin
				valid_q[idx][victim] <= 1'b1;
				dirty_q[idx][victim] <= 1'b0;  // fresh copy of memory
				repl_q[idx]          <= ~victim;
			end
			if (st.clean) begin
				dirty_q[idx][victim] <= 1'b0;
			end
			if (st.write_hit) begin
				dirty_q[idx][st.hit_way] <= 1'b1;
			end
			// point away from the way just used
			if (read_hit || st.write_hit) begin
				repl_q[idx] <= ~st.hit_way;
			end
		end
	end

	// ----------------------------------------
	// tags and line data
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (st.fill) begin
			data_q[idx][victim] <= mem_rdata;
			tag_q[idx][victim]  <= req_tag;
		end else if (st.write_hit) begin
			data_q[idx][st.hit_way][word_sel*WORD_BITS +: WORD_BITS] <= proc_wdata;
		end
	end

endmodule

`default_nettype wire

//--- source/dcache_ctrl.sv
// miss handling controller
`timescale 1ns/100ps
`default_nettype none

module dcache_ctrl (
	input  logic                   clk,
	input  logic                   proc_reset,
	input  logic                   proc_read,
	input  logic                   proc_write,
	input  dcache_pkg::word_addr_t proc_addr,
	input  logic                   mem_ready,
	output logic                   proc_stall,
	output logic                   mem_read,
	output logic                   mem_write,
	output dcache_pkg::line_addr_t mem_addr,
	dcache_store_if.ctrl           st
);
	import dcache_pkg::*;

	cache_state_t state_q;
	cache_state_t state_d;
	logic         miss;

	// request that found no valid matching tag
	assign miss = (proc_read || proc_write) && !st.hit;

	// ----------------------------------------
	// next state and outputs
	// ----------------------------------------
	always_comb begin
		state_d      = state_q;
		proc_stall   = 1'b0;
		mem_read     = 1'b0;
		mem_write    = 1'b0;
		mem_addr     = '0;
		st.write_hit = 1'b0;
		st.fill      = 1'b0;
		st.clean     = 1'b0;

		case (state_q)
			compare_tag: begin
				proc_stall   = miss;
				st.write_hit = proc_write && st.hit;
				if (miss) begin
					if (st.victim_dirty) begin
						state_d = write_back;
					end else begin
						state_d = allocate;
					end
				end
			end

			write_back: begin
				proc_stall = 1'b1;
				mem_addr   = st.victim_line_addr;
				mem_write  = !mem_ready;  // drop in the ready cycle
				if (mem_ready) begin
					st.clean = 1'b1;
					state_d  = allocate;
				end
			end

			allocate: begin
				proc_stall = 1'b1;
				mem_addr   = proc_addr[WORD_ADDR_BITS-1:2];
				mem_read   = !mem_ready;
				if (mem_ready) begin
					st.fill = 1'b1;  // mem_rdata valid now
					state_d = compare_tag;
				end
			end

			default: begin
				state_d = compare_tag;
			end
		endcase
	end

	// ----------------------------------------
	// state register
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state_q <= compare_tag;
		end else begin
			state_q <= state_d;
		end
	end

endmodule

`default_nettype wire

//--- source/dcache_top.sv
// data cache top level
`timescale 1ns/100ps
`default_nettype none

module dcache_top (
	input  logic                   clk,
	input  logic                   proc_reset,
	// processor side
	input  logic                   proc_read,
	input  logic                   proc_write,
	input  dcache_pkg::word_addr_t proc_addr,
	input  dcache_pkg::word_t      proc_wdata,
	output dcache_pkg::word_t      proc_rdata,
	output logic                   proc_stall,
	// memory side
	output logic                   mem_read,
	output logic                   mem_write,
	output dcache_pkg::line_addr_t mem_addr,
	output dcache_pkg::line_t      mem_wdata,
	input  dcache_pkg::line_t      mem_rdata,
	input  logic                   mem_ready
);

	dcache_store_if st_if (.clk(clk));

	dcache_ctrl u_ctrl (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (proc_read),
		.proc_write (proc_write),
		.proc_addr  (proc_addr),
		.mem_ready  (mem_ready),
		.proc_stall (proc_stall),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.st         (st_if.ctrl)
	);

	dcache_store u_store (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (proc_read),
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.mem_rdata  (mem_rdata),
		.proc_rdata (proc_rdata),
		.st         (st_if.store)
	);

	// victim data goes out on write-back
	assign mem_wdata = st_if.victim_line;

endmodule

`default_nettype wire

//--- sim/slow_mem.sv
// line-wide memory model
`timescale 1ns/100ps
`default_nettype none

module slow_mem (
	input  logic                   clk,
	input  logic                   proc_reset,
	input  logic                   mem_read,
	input  logic                   mem_write,
	input  dcache_pkg::line_addr_t mem_addr,
	input  dcache_pkg::line_t      mem_wdata,
	output dcache_pkg::line_t      mem_rdata,
	output logic                   mem_ready,
	output int                     read_count,
	output int                     write_count,
	output dcache_pkg::line_addr_t last_write_addr,
	output dcache_pkg::line_t      last_write_line
);
	import dcache_pkg::*;

	line_t       mem_q [32];  // tags 0..7 over all indexes
	line_addr_t  addr_q;
	line_t       wdata_q;
	logic        busy;
	logic        is_write;
	logic [2:0]  wait_cnt;
	logic [31:0] rand_state = 32'd57606;

	function automatic word_t fill_word(word_addr_t a);
		return (32'(a) * 32'h0100_0193) ^ 32'hC0DE_0000;
	endfunction

	// lcg step, delay of 1 to 4 cycles
	function logic [2:0] next_delay();
		rand_state = rand_state * 32'd1103515245 + 32'd12345;
		return {1'b0, rand_state[29:28]} + 3'd1;
	endfunction

	always @(posedge clk) begin
		if (proc_reset) begin
			for (int la = 0; la < 32; la++) begin
				for (int w = 0; w < WORDS_PER_LINE; w++) begin
					mem_q[la][w*WORD_BITS +: WORD_BITS] <= fill_word(word_addr_t'(la * 4 + w));
				end
			end
			busy        <= 1'b0;
			mem_ready   <= 1'b0;
			read_count  <= 0;
			write_count <= 0;
		end else if (mem_ready) begin
			if (is_write) begin
				mem_q[addr_q[4:0]] <= wdata_q;  // commit at end of ready cycle
				last_write_addr    <= addr_q;
				last_write_line    <= wdata_q;
			end
			mem_ready <= 1'b0;
			busy      <= 1'b0;
		end else if (busy) begin
			if (wait_cnt == 3'd1) begin
				mem_ready <= 1'b1;
			end else begin
				wait_cnt <= wait_cnt - 3'd1;
			end
		end else if (mem_read || mem_write) begin
			busy     <= 1'b1;
			is_write <= mem_write;
			addr_q   <= mem_addr;
			wdata_q  <= mem_wdata;
			wait_cnt <= next_delay();
			if (mem_write) begin
				write_count <= write_count + 1;
			end else begin
				read_count <= read_count + 1;
			end
		end
	end

	assign mem_rdata = mem_q[addr_q[4:0]];  // valid in the ready cycle

endmodule

`default_nettype wire

//--- sim/dcache_tb.sv
// data cache testbench
`timescale 1ns/100ps
`default_nettype none

module dcache_tb;
	import dcache_pkg::*;

	localparam int NUM_RANDOM = 300;
	localparam int NUM_OPS    = NUM_RANDOM + 20;  // directed plus random

	logic        clk = 1'b0;
	logic        proc_reset;
	logic        proc_read;
	logic        proc_write;
	word_addr_t  proc_addr;
	word_t       proc_wdata;
	word_t       proc_rdata;
	logic        proc_stall;
	logic        mem_read;
	logic        mem_write;
	line_addr_t  mem_addr;
	line_t       mem_wdata;
	line_t       mem_rdata;
	logic        mem_ready;
	int          read_count;
	int          write_count;
	line_addr_t  last_write_addr;
	line_t       last_write_line;

	word_t       shadow [128];  // expected memory image, tags 0..7
	word_t       exp_rdata;
	logic [31:0] rand_state = 32'd57606;
	int          reads_issued = 0;
	int          reads_checked = 0;

	dcache_top i_dut (.*);
	slow_mem   i_mem (.*);

	always #50 clk = ~clk;

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic word_t pattern_word(word_addr_t a);
		return (32'(a) * 32'h0100_0193) ^ 32'hC0DE_0000;
	endfunction

	function automatic word_t ref_read(word_addr_t a);
		return shadow[a[6:0]];
	endfunction

	function logic [31:0] next_rand();
		rand_state = rand_state * 32'd1103515245 + 32'd12345;
		return rand_state;
	endfunction

	// ----------------------------------------
	// checks
	// ----------------------------------------
	task automatic stop_on_error();
		$display("Verification failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp) begin
			$display("mismatch %s got %h expected %h", name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_line_addr(string name, line_addr_t got, line_addr_t exp);
		if (got !== exp) begin
			$display("mismatch %s got %h expected %h", name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_level(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("mismatch %s got %h expected %h", name, got, exp);
			stop_on_error();
		end
	endtask

	// one request, held until the stall drops
	task automatic access(input logic wr, input word_addr_t a, input word_t d);
		proc_read  = !wr;
		proc_write = wr;
		proc_addr  = a;
		proc_wdata = d;
		exp_rdata  = ref_read(a);
		if (!wr) begin
			reads_issued++;
		end
		@(negedge clk);
		while (proc_stall) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		if (wr) begin
			shadow[a[6:0]] = d;
		end
		proc_read  = 1'b0;
		proc_write = 1'b0;
	endtask

	// compare process, mid cycle where outputs are settled
	always @(negedge clk) begin
		if (!proc_reset) begin
			if (proc_read && !proc_stall) begin
				reads_checked++;
				check_word("proc_rdata", proc_rdata, exp_rdata);
			end else begin
				check_word("proc_rdata idle", proc_rdata, '0);
			end
			check_level("mem_read with mem_write", mem_read && mem_write, 1'b0);
		end
	end

	// watchdog
	initial begin
		#((NUM_OPS * 14 + 10) * 100);
		$display("timeout, the cache did not finish %0d operations in time", NUM_OPS);
		stop_on_error();
	end

	initial begin
		int          rc;
		int          wc;
		logic [31:0] r;
		proc_reset = 1'b1;
		proc_read  = 1'b0;
		proc_write = 1'b0;
		proc_addr  = '0;
		proc_wdata = '0;
		for (int i = 0; i < 128; i++) begin
			shadow[i] = pattern_word(word_addr_t'(i));
		end
		repeat (2) @(posedge clk);
		#1;
		proc_reset = 1'b0;

		// quiet after reset
		@(negedge clk);
		check_level("proc_stall", proc_stall, 1'b0);
		check_level("mem_read", mem_read, 1'b0);
		check_level("mem_write", mem_write, 1'b0);
		@(posedge clk);
		#1;

		// cold read, then same line
		rc = read_count;
		access(1'b0, 30'h01, '0);
		check_level("mem_read on cold read", read_count != rc, 1'b1);
		rc = read_count;
		access(1'b0, 30'h02, '0);
		check_level("mem_read on line hit", read_count != rc, 1'b0);

		// write hit, no memory traffic
		rc = read_count;
		wc = write_count;
		access(1'b1, 30'h03, 32'hDEAD_BEEF);
		access(1'b0, 30'h03, '0);
		check_level("memory strobe on write hit", (read_count != rc) || (write_count != wc), 1'b0);

		// ----------------------------------------
		// dirty eviction at index 2
		// ----------------------------------------
		access(1'b1, 30'h19, 32'h1234_5678);  // tag 1, word 1
		access(1'b0, 30'h28, '0);
		wc = write_count;
		access(1'b0, 30'h38, '0);  // evicts tag 1
		check_level("mem_write on eviction", write_count != wc, 1'b1);
		check_line_addr("mem_addr", last_write_addr, 28'h6);
		check_word("mem_wdata word 1", last_write_line[63:32], 32'h1234_5678);
		access(1'b0, 30'h19, '0);

		// random mix over tags 0..7
		for (int n = 0; n < NUM_RANDOM; n++) begin
			r = next_rand();
			access(r[27], {23'd0, r[22:16]}, next_rand());
		end

		if (reads_checked == reads_issued) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("compare process checked %0d of %0d reads", reads_checked, reads_issued);
			stop_on_error();
		end
	end

endmodule

`default_nettype wire

//--- verilog.f
source/dcache_pkg.sv
source/dcache_store_if.sv
source/dcache_store.sv
source/dcache_ctrl.sv
source/dcache_top.sv
sim/slow_mem.sv
sim/dcache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/100ps --top-module dcache_tb \
	-f verilog.f -o dcache_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/dcache_sim > "$log" 2>&1
run_status=$?
cat "$log"

if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "Verification passed" "$log"; then
	exit 0
fi
echo "pass message not found in $log"
exit 1
